/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = cmd_phys_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
PASS_MSG   = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/cmd_phys_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_phys_checker (
	input logic sd_clock,
	input logic rst_n,
	input logic ack_in,
	input logic idle_in,
	input logic ack_out,
	input logic strobe_out,
	input logic command_timeout,
	input logic crc_error,
	input logic cmd_out,
	input logic cmd_oe
);
	int oe_len; // cycles cmd_oe has been high so far
	int fails = 0;

	always_ff @(posedge sd_clock) begin
		if (!rst_n || !cmd_oe)
			oe_len <= 0;
		else
			oe_len <= oe_len + 1;
	end

	// accepted request puts the frame on the line next cycle
	ack_then_oe: assert property (@(posedge sd_clock) disable iff (!rst_n)
		ack_out |=> cmd_oe)
		else begin
			$error("cmd_oe did not rise the cycle after ack_out");
			fails++;
		end

	oe_not_long: assert property (@(posedge sd_clock) disable iff (!rst_n)
		cmd_oe |-> oe_len < 48)
		else begin
			$error("cmd_oe high for more than 48 cycles");
			fails++;
		end

	oe_exact: assert property (@(posedge sd_clock) disable iff (!rst_n)
		$fell(cmd_oe) |-> oe_len == 48)
		else begin
			$error("cmd_oe dropped after %0d cycles instead of 48", oe_len);
			fails++;
		end

	// status flags only show up together with strobe_out
	flags_with_strobe: assert property (@(posedge sd_clock) disable iff (!rst_n)
		(command_timeout || crc_error) |-> strobe_out)
		else begin
			$error("status flag raised without strobe_out");
			fails++;
		end

	timeout_or_crc: assert property (@(posedge sd_clock) disable iff (!rst_n)
		!(command_timeout && crc_error))
		else begin
			$error("command_timeout and crc_error both set");
			fails++;
		end

	strobe_hold: assert property (@(posedge sd_clock) disable iff (!rst_n)
		strobe_out && !ack_in && !idle_in |=> strobe_out)
		else begin
			$error("strobe_out dropped before ack_in");
			fails++;
		end

	quiet_in_reset: assert property (@(posedge sd_clock)
		!rst_n |=> !ack_out && !strobe_out && !command_timeout && !crc_error
			&& !cmd_oe && cmd_out)
		else begin
			$error("output active during reset");
			fails++;
		end

endmodule

bind cmd_phys cmd_phys_checker u_checker (
	.sd_clock(sd_clock),
	.rst_n(rst_n),
	.ack_in(ack_in),
	.idle_in(idle_in),
	.ack_out(ack_out),
	.strobe_out(strobe_out),
	.command_timeout(command_timeout),
	.crc_error(crc_error),
	.cmd_out(cmd_out),
	.cmd_oe(cmd_oe)
);

`default_nettype wire

/* dv/cmd_phys_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sd_cmd_consts.svh"

module cmd_phys_tb;
	localparam int TIMEOUT = 200;

	logic sd_clock;
	logic rst_n;
	logic strobe_in, ack_in, idle_in, timeout_enable, cmd_in;
	logic [39:0] cmd_to_send;
	logic ack_out, strobe_out, command_timeout, crc_error, cmd_out, cmd_oe;
	logic [135:0] response;
	logic [47:0] frame; // last frame seen on cmd_out
	int errors;
	int seed;

	cmd_phys uut (
		.sd_clock(sd_clock),
		.rst_n(rst_n),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.timeout_enable(timeout_enable),
		.cmd_to_send(cmd_to_send),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.command_timeout(command_timeout),
		.crc_error(crc_error),
		.response(response),
		.cmd_in(cmd_in),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	always #20 sd_clock = ~sd_clock;

	// crc7 over 40 bits, generator x^7 + x^3 + 1
	function automatic logic [6:0] crc7_of(input logic [39:0] bits);
		logic [6:0] c;
		logic fb;
		c = '0;
		for (int i = 39; i >= 0; i--) begin
			fb = c[6] ^ bits[i];
			c = {c[5:0], 1'b0};
			if (fb)
				c = c ^ 7'h09;
		end
		return c;
	endfunction

	function automatic logic [47:0] short_rsp(input logic [5:0] idx, input logic [31:0] arg);
		logic [39:0] head;
		head = {2'b00, idx, arg}; // start 0, card to host
		return {head, crc7_of(head), 1'b1};
	endfunction

	function automatic logic flag_of(input int sel);
		case (sel)
			0: return ack_out;
			1: return cmd_oe;
			default: return strobe_out;
		endcase
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [135:0] got,
			input logic [135:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// polls at the falling edge until the flag is high
	task automatic wait_high(input int sel, input string what);
		int n;
		n = 0;
		while (flag_of(sel) !== 1'b1 && n < TIMEOUT) begin
			@(negedge sd_clock);
			n++;
		end
		assert (n < TIMEOUT) else begin
			errors++;
			$display("%s did not rise within %0d cycles", what, TIMEOUT);
		end
	endtask

	task automatic send_command(input logic [39:0] cmd);
		int n;
		frame = '0;
		@(negedge sd_clock);
		cmd_to_send = cmd;
		strobe_in = 1'b1;
		@(negedge sd_clock);
		wait_high(0, "ack_out");
		strobe_in = 1'b0;
		@(negedge sd_clock);
		wait_high(1, "cmd_oe");
		n = 0;
		while (cmd_oe === 1'b1 && n < `SD_CMD_LEN) begin
			frame = {frame[46:0], cmd_out};
			n++;
			@(negedge sd_clock);
		end
		check_word("cmd frame", {88'd0, frame}, {88'd0, cmd, crc7_of(cmd), 1'b1});
	endtask

	// card model, answers after a random gap, msb first
	task automatic card_respond(input logic [135:0] bits, input int len);
		int gap;
		gap = 2 + int'($unsigned($random(seed)) % 19);
		repeat (gap - 1) @(negedge sd_clock);
		for (int i = len - 1; i >= 0; i--) begin
			cmd_in = bits[i];
			@(negedge sd_clock);
		end
		cmd_in = 1'b1;
	endtask

	task automatic ack_response();
		repeat (3) @(negedge sd_clock); // host holds off the ack
		ack_in = 1'b1;
		@(negedge sd_clock);
		ack_in = 1'b0;
		check_bit("strobe_out", strobe_out, 1'b0);
	endtask

	task automatic run_short(input logic [5:0] idx, input logic bad_crc);
		logic [31:0] arg;
		logic [47:0] rsp;
		arg = $random(seed);
		send_command({2'b01, idx, arg});
		arg = $random(seed); // card status
		rsp = short_rsp(idx, arg);
		if (bad_crc)
			rsp[3] = ~rsp[3]; // inside the crc field
		card_respond({88'd0, rsp}, `SD_CMD_LEN);
		wait_high(2, "strobe_out");
		check_word("response", response, {88'd0, rsp});
		check_bit("crc_error", crc_error, bad_crc);
		check_bit("command_timeout", command_timeout, 1'b0);
		ack_response();
	endtask

	task automatic run_long(input logic [5:0] idx);
		logic [31:0] arg;
		logic [135:0] rsp;
		arg = $random(seed);
		send_command({2'b01, idx, arg});
		rsp[127:0] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		rsp[135:128] = 8'h3f; // start, dir, reserved ones
		rsp[0] = 1'b1;
		card_respond(rsp, `SD_RSP_LONG_LEN);
		wait_high(2, "strobe_out");
		check_word("response", response, rsp);
		check_bit("crc_error", crc_error, 1'b0);
		check_bit("command_timeout", command_timeout, 1'b0);
		ack_response();
	endtask

	initial begin
		seed = 16467;
		errors = 0;
		sd_clock = 1'b0;
		rst_n = 1'b0;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		timeout_enable = 1'b0;
		cmd_in = 1'b1;
		cmd_to_send = '0;
		repeat (2) @(negedge sd_clock);
		check_bit("ack_out", ack_out, 1'b0);
		check_bit("strobe_out", strobe_out, 1'b0);
		check_bit("command_timeout", command_timeout, 1'b0);
		check_bit("crc_error", crc_error, 1'b0);
		check_bit("cmd_oe", cmd_oe, 1'b0);
		check_bit("cmd_out", cmd_out, 1'b1);
		repeat (2) @(negedge sd_clock);
		rst_n = 1'b1;

		run_short(6'd17, 1'b0);
		run_short(6'd17, 1'b1);
		run_long(`SD_IDX_ALL_SEND_CID);
		run_long(`SD_IDX_SEND_CSD);
		run_long(`SD_IDX_SEND_CID);

		// silent card, timeout on
		timeout_enable = 1'b1;
		send_command({2'b01, 6'd13, 32'h0001_0000});
		wait_high(2, "strobe_out");
		check_bit("command_timeout", command_timeout, 1'b1);
		check_bit("crc_error", crc_error, 1'b0);
		check_word("response", response, '0);
		ack_response();

		// silent card, timeout off, host gives up with idle_in
		timeout_enable = 1'b0;
		send_command({2'b01, 6'd13, 32'h0001_0000});
		for (int i = 0; i < 100; i++) begin
			@(negedge sd_clock);
			check_bit("strobe_out", strobe_out, 1'b0);
		end
		idle_in = 1'b1;
		@(negedge sd_clock);
		idle_in = 1'b0;
		run_short(6'd17, 1'b0);

		errors += uut.u_checker.fails;
		$display("checks done, %0d error(s)", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/sd_cmd_pkg.sv
source/cmd_line_if.sv
source/cmd_serializer.sv
source/cmd_deserializer.sv
source/cmd_phys_controller.sv
source/cmd_phys.sv
dv/cmd_phys_checker.sv
dv/cmd_phys_tb.sv

/* source/cmd_deserializer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sd_cmd_consts.svh"

module cmd_deserializer (
	input logic sd_clock,
	input logic rst_n,
	cmd_line_if.rx line,
	input logic cmd_in,
	input logic timeout_enable
);
	localparam logic [7:0] SHORT_LAST = 8'(`SD_CMD_LEN - 1);
	localparam logic [7:0] LONG_LAST = 8'(`SD_RSP_LONG_LEN - 1);
	localparam logic [7:0] CRC_SPAN = 8'(`SD_CMD_LEN - 8); // bits covered by crc7
	localparam logic [6:0] NCR_LAST = 7'(`SD_NCR_MAX - 1);

	logic hunt_q;  // armed, looking for start bit
	logic recv_q;
	logic long_q;
	logic to_en_q;
	logic done_q;
	logic timeout_q;
	logic [6:0] wait_q;
	logic [7:0] cnt_q;
	logic [6:0] crc_q;
	logic [7:0] last_bit;
	sd_cmd_pkg::rsp_word_u word_q;

	assign last_bit = long_q ? LONG_LAST : SHORT_LAST;

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			hunt_q <= 1'b0;
			recv_q <= 1'b0;
			long_q <= 1'b0;
			to_en_q <= 1'b0;
			done_q <= 1'b0;
			timeout_q <= 1'b0;
			wait_q <= '0;
			cnt_q <= '0;
			crc_q <= '0;
		end else begin
			done_q <= 1'b0;
			timeout_q <= 1'b0;
			if (line.rx_abort) begin
				hunt_q <= 1'b0;
				recv_q <= 1'b0;
			end else if (line.rx_arm) begin
				hunt_q <= 1'b1;
				recv_q <= 1'b0;
				long_q <= line.rx_long;
				to_en_q <= timeout_enable; // taken with the arm
				wait_q <= '0;
			end else if (hunt_q) begin
				if (!cmd_in) begin
					// start bit counts as bit 0
					hunt_q <= 1'b0;
					recv_q <= 1'b1;
					cnt_q <= 8'd1;
					crc_q <= sd_cmd_pkg::crc7_next(7'd0, 1'b0);
				end else if (to_en_q && wait_q == NCR_LAST) begin
					hunt_q <= 1'b0;
					timeout_q <= 1'b1;
				end else begin
					wait_q <= wait_q + 7'd1;
				end
			end else if (recv_q) begin
				cnt_q <= cnt_q + 8'd1;
				if (cnt_q < CRC_SPAN)
					crc_q <= sd_cmd_pkg::crc7_next(crc_q, cmd_in);
				if (cnt_q == last_bit) begin
					recv_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	// cleared on arm so short responses come out zero extended
	always_ff @(posedge sd_clock) begin
		if (line.rx_arm)
			word_q <= '0;
		else if (recv_q)
			word_q <= {word_q[134:0], cmd_in};
	end

	assign line.rx_done = done_q;
	assign line.rx_timeout = timeout_q;
	assign line.rx_word = word_q;
	// R2 crc lives inside cid/csd, only short frames are checked
	assign line.rx_crc_bad = !long_q &&
		((word_q.short_rsp.crc != crc_q) || !word_q.short_rsp.end_bit);

endmodule

`default_nettype wire

/* source/cmd_line_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface cmd_line_if;
	logic tx_start;
	logic [39:0] tx_cmd;
	logic tx_done;
	logic rx_arm;
	logic rx_long;    // valid with rx_arm
	logic rx_abort;
	logic rx_done;
	logic rx_timeout;
	logic rx_crc_bad; // valid with rx_done
	sd_cmd_pkg::rsp_word_u rx_word;

	modport ctrl (
		output tx_start, tx_cmd, rx_arm, rx_long, rx_abort,
		input tx_done, rx_done, rx_timeout, rx_crc_bad, rx_word
	);
	modport tx (input tx_start, tx_cmd, output tx_done);
	modport rx (
		input rx_arm, rx_long, rx_abort,
		output rx_done, rx_timeout, rx_crc_bad, rx_word
	);
	// read only view for protocol checks
	modport mon (
		input tx_start, tx_cmd, tx_done, rx_arm, rx_long, rx_abort,
		input rx_done, rx_timeout, rx_crc_bad, rx_word
	);
endinterface

`default_nettype wire

/* source/cmd_phys.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_phys (
	input logic sd_clock,
	input logic rst_n,
	// host side
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input logic timeout_enable,
	input logic [39:0] cmd_to_send,
	output logic ack_out,
	output logic strobe_out,
	output logic command_timeout,
	output logic crc_error,
	output logic [135:0] response,
	// card side, pad lives outside
	input logic cmd_in,
	output logic cmd_out,
	output logic cmd_oe
);
	cmd_line_if line ();

	cmd_phys_controller u_ctrl (
		.sd_clock(sd_clock),
		.rst_n(rst_n),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.timeout_enable(timeout_enable),
		.cmd_to_send(cmd_to_send),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.command_timeout(command_timeout),
		.crc_error(crc_error),
		.response(response),
		.line(line.ctrl)
	);

	cmd_serializer u_tx (
		.sd_clock(sd_clock),
		.rst_n(rst_n),
		.line(line.tx),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	cmd_deserializer u_rx (
		.sd_clock(sd_clock),
		.rst_n(rst_n),
		.line(line.rx),
		.cmd_in(cmd_in),
		.timeout_enable(timeout_enable)
	);

endmodule

`default_nettype wire

/* source/cmd_phys_controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sd_cmd_consts.svh"

module cmd_phys_controller (
	input logic sd_clock,
	input logic rst_n,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input logic timeout_enable,
	input logic [39:0] cmd_to_send,
	output logic ack_out,
	output logic strobe_out,
	output logic command_timeout,
	output logic crc_error,
	output logic [135:0] response,
	cmd_line_if.ctrl line
);
	sd_cmd_pkg::ctrl_state_e state_q;
	sd_cmd_pkg::rsp_word_u resp_q;
	logic [39:0] cmd_q;
	logic [5:0] cmd_idx;
	logic is_long;
	logic long_q;
	logic start_q;
	logic arm_q;
	logic abort_q;

	assign cmd_idx = cmd_to_send[37:32];
	assign is_long = (cmd_idx == `SD_IDX_ALL_SEND_CID) ||
		(cmd_idx == `SD_IDX_SEND_CSD) || (cmd_idx == `SD_IDX_SEND_CID);

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			state_q <= sd_cmd_pkg::IDLE;
			resp_q <= '0;
			long_q <= 1'b0;
			ack_out <= 1'b0;
			strobe_out <= 1'b0;
			command_timeout <= 1'b0;
			crc_error <= 1'b0;
			start_q <= 1'b0;
			arm_q <= 1'b0;
			abort_q <= 1'b0;
		end else begin
			ack_out <= 1'b0;
			start_q <= 1'b0;
			arm_q <= 1'b0;
			abort_q <= idle_in;
			if (idle_in) begin
				// forced back to idle from anywhere
				state_q <= sd_cmd_pkg::IDLE;
				resp_q <= '0;
				strobe_out <= 1'b0;
				command_timeout <= 1'b0;
				crc_error <= 1'b0;
			end else begin
				case (state_q)
					sd_cmd_pkg::IDLE: begin
						if (strobe_in) begin
							state_q <= sd_cmd_pkg::SEND;
							ack_out <= 1'b1;
							start_q <= 1'b1;
							long_q <= is_long;
						end
					end
					sd_cmd_pkg::SEND: begin
						if (line.tx_done) begin
							state_q <= sd_cmd_pkg::WAIT_RSP;
							arm_q <= 1'b1;
						end
					end
					sd_cmd_pkg::WAIT_RSP: begin
						if (line.rx_done) begin
							state_q <= sd_cmd_pkg::REPORT;
							resp_q <= line.rx_word;
							crc_error <= line.rx_crc_bad;
							command_timeout <= 1'b0;
							strobe_out <= 1'b1;
						end else if (line.rx_timeout && timeout_enable) begin
							state_q <= sd_cmd_pkg::REPORT;
							resp_q <= '0; // nothing came back
							crc_error <= 1'b0;
							command_timeout <= 1'b1;
							strobe_out <= 1'b1;
						end
					end
					sd_cmd_pkg::REPORT: begin
						// hold everything until the host acks
						if (ack_in) begin
							state_q <= sd_cmd_pkg::IDLE;
							resp_q <= '0;
							strobe_out <= 1'b0;
							command_timeout <= 1'b0;
							crc_error <= 1'b0;
						end
					end
					default: state_q <= sd_cmd_pkg::IDLE;
				endcase
			end
		end
	end

	// command latched at accept, held for the serializer load
	always_ff @(posedge sd_clock) begin
		if (state_q == sd_cmd_pkg::IDLE && strobe_in && !idle_in)
			cmd_q <= cmd_to_send;
	end

	assign line.tx_start = start_q;
	assign line.tx_cmd = cmd_q;
	assign line.rx_arm = arm_q;
	assign line.rx_long = long_q;
	assign line.rx_abort = abort_q;
	assign response = resp_q;

endmodule

`default_nettype wire

/* source/cmd_serializer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sd_cmd_consts.svh"

module cmd_serializer (
	input logic sd_clock,
	input logic rst_n,
	cmd_line_if.tx line,
	output logic cmd_out,
	output logic cmd_oe
);
	localparam logic [5:0] LAST_BIT = 6'(`SD_CMD_LEN - 1);
	// last bit of start/dir/index/arg, crc covers up to here
	localparam logic [5:0] LAST_PAYLOAD = 6'(`SD_CMD_LEN - 9);

	logic [47:0] shift_q;
	logic [5:0] cnt_q;
	logic [6:0] crc_q;
	logic oe_q;
	logic [6:0] crc_nxt;

	assign crc_nxt = sd_cmd_pkg::crc7_next(crc_q, shift_q[47]);

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			oe_q <= 1'b0;
			cnt_q <= '0;
			crc_q <= '0;
		end else if (line.tx_start) begin
			oe_q <= 1'b1;
			cnt_q <= '0;
			crc_q <= '0;
		end else if (oe_q) begin
			cnt_q <= cnt_q + 6'd1;
			if (cnt_q == LAST_BIT)
				oe_q <= 1'b0;
			if (cnt_q <= LAST_PAYLOAD)
				crc_q <= crc_nxt;
		end
	end

	// frame shifter, msb goes out first
	always_ff @(posedge sd_clock) begin
		if (line.tx_start) begin
			shift_q <= {line.tx_cmd, 8'h01};
		end else if (oe_q) begin
			if (cnt_q == LAST_PAYLOAD)
				shift_q <= {crc_nxt, 1'b1, 40'd0}; // splice crc and end bit in
			else
				shift_q <= {shift_q[46:0], 1'b0};
		end
	end

	assign cmd_oe = oe_q;
	assign cmd_out = oe_q ? shift_q[47] : 1'b1; // line idles high
	assign line.tx_done = oe_q && (cnt_q == LAST_BIT);

endmodule

`default_nettype wire

/* source/sd_cmd_consts.svh */
`ifndef SD_CMD_CONSTS_SVH
`define SD_CMD_CONSTS_SVH

// frame lengths on the CMD line, in bits
`define SD_CMD_LEN 48
`define SD_RSP_LONG_LEN 136

// cycles allowed between arm and the card's start bit
`define SD_NCR_MAX 64

// indices answered with a 136-bit R2 response
`define SD_IDX_ALL_SEND_CID 6'd2
`define SD_IDX_SEND_CSD 6'd9
`define SD_IDX_SEND_CID 6'd10

`endif

/* source/sd_cmd_pkg.sv */
`default_nettype none

package sd_cmd_pkg;

	// short response, right aligned in the 136-bit word
	typedef struct packed {
		logic [87:0] unused;
		logic start;
		logic dir;
		logic [5:0] index;
		logic [31:0] arg;
		logic [6:0] crc;
		logic end_bit;
	} rsp_short_s;

	// R2 response, CID/CSD carries its own crc inside
	typedef struct packed {
		logic start;
		logic dir;
		logic [5:0] rsvd;
		logic [126:0] cid_csd;
		logic end_bit;
	} rsp_long_s;

	typedef union packed {
		rsp_short_s short_rsp;
		rsp_long_s long_rsp;
	} rsp_word_u;

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		WAIT_RSP,
		REPORT
	} ctrl_state_e;

	// one step of crc7, poly x^7 + x^3 + 1
	function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
		logic fb;
		fb = crc[6] ^ din;
		return {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
	endfunction

endpackage

`default_nettype wire
